//--- common/cache_pkg.sv
package cache_pkg;

    ////////////////////
    // Cache geometry
    ////////////////////

    // Word select within a line
    localparam int OFFSET_WIDTH    = 3;
    // Set select
    localparam int INDEX_WIDTH     = 6;
    // Byte address minus the two byte-select bits
    localparam int WORD_ADDR_WIDTH = 30;
    localparam int TAG_WIDTH       = WORD_ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int LINE_WORDS      = 1 << OFFSET_WIDTH;
    localparam int NUM_SETS        = 1 << INDEX_WIDTH;

    // Data word and its byte lanes
    localparam int WORD_WIDTH      = 32;
    localparam int BYTES_PER_WORD  = WORD_WIDTH / 8;

    ////////////////////
    // Vector types
    ////////////////////

    typedef logic [WORD_WIDTH-1:0]      word_t;
    typedef logic [BYTES_PER_WORD-1:0]  byte_en_t;
    typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [TAG_WIDTH-1:0]       tag_t;
    typedef logic [INDEX_WIDTH-1:0]     index_t;
    typedef logic [OFFSET_WIDTH-1:0]    offset_t;

    ////////////////////
    // Controller FSM
    ////////////////////

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL
    } ctrl_state_t;

endpackage

//--- common/cache_port_if.sv
interface cache_port_if;

    // Request fields toward the array
    logic                 enable;
    cache_pkg::index_t    index;
    cache_pkg::offset_t   word_sel;
    logic                 cmp;
    logic                 write;
    cache_pkg::tag_t      tag_in;
    cache_pkg::word_t     data_in;
    logic                 valid_in;
    cache_pkg::byte_en_t  byte_w_en;

    // Result fields back to the requester
    logic                 hit;
    logic                 dirty;
    cache_pkg::tag_t      tag_out;
    cache_pkg::word_t     data_out;
    logic                 valid_out;

    modport ctrl (
        output enable, index, word_sel, cmp, write, tag_in, data_in, valid_in, byte_w_en,
        input  hit, dirty, tag_out, data_out, valid_out
    );

    modport array (
        input  enable, index, word_sel, cmp, write, tag_in, data_in, valid_in, byte_w_en,
        output hit, dirty, tag_out, data_out, valid_out
    );

endinterface

//--- cache_2ways/cache_oneline.sv
module cache_oneline (
    input logic         clk,
    input logic         rst,
    cache_port_if.array port
);

    ////////////////////
    // Storage
    ////////////////////

    // One tag per set
    cache_pkg::tag_t  tag_mem  [cache_pkg::NUM_SETS];
    // Line data, set by word
    cache_pkg::word_t data_mem [cache_pkg::NUM_SETS][cache_pkg::LINE_WORDS];
    // Per-set state bits
    logic [cache_pkg::NUM_SETS-1:0] valid_bits;
    logic [cache_pkg::NUM_SETS-1:0] dirty_bits;

    logic wr_en;

    assign wr_en = port.enable && port.write;

    ////////////////////
    // Combinational read
    ////////////////////

    // Tag match only, valid is qualified by the caller
    assign port.hit       = (tag_mem[port.index] == port.tag_in);
    assign port.tag_out   = tag_mem[port.index];
    assign port.data_out  = data_mem[port.index][port.word_sel];
    assign port.valid_out = valid_bits[port.index];
    assign port.dirty     = dirty_bits[port.index];

    ////////////////////
    // Data and tag write
    ////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (port.cmp) begin
                // Store hit, merge selected byte lanes
                for (int b = 0; b < cache_pkg::BYTES_PER_WORD; b++) begin
                    if (port.byte_w_en[b]) begin
                        data_mem[port.index][port.word_sel][8*b +: 8] <= port.data_in[8*b +: 8];
                    end
                end
            end else begin
                // Refill word, whole word plus new tag
                data_mem[port.index][port.word_sel] <= port.data_in;
                tag_mem[port.index] <= port.tag_in;
            end
        end
    end

    ////////////////////
    // Valid and dirty
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (wr_en) begin
            if (port.cmp) begin
                // CPU store marks line modified
                dirty_bits[port.index] <= 1'b1;
            end else begin
                // Refill leaves a clean line
                valid_bits[port.index] <= port.valid_in;
                dirty_bits[port.index] <= 1'b0;
            end
        end
    end

endmodule

//--- cache_2ways/victim_select.sv
module victim_select (
    input  logic              clk,
    input  logic              rst,
    input  cache_pkg::index_t index,
    input  logic              valid0,
    input  logic              valid1,
    input  logic              dirty0,
    input  logic              dirty1,
    input  logic              touch,
    input  logic              touch_way,
    output logic              victim,
    output logic              victim_dirty
);

    // One bit per set, names the least recently used way
    logic [cache_pkg::NUM_SETS-1:0] lru;

    always_ff @(posedge clk) begin
        if (rst) begin
            lru <= '0;
        end else if (touch) begin
            // Point away from the way just used
            lru[index] <= ~touch_way;
        end
    end

    // Empty ways first, way0 before way1, then LRU
    always_comb begin
        if (!valid0) begin
            victim = 1'b0;
        end else if (!valid1) begin
            victim = 1'b1;
        end else begin
            victim = lru[index];
        end
    end

    // Dirty state of whichever way gets picked
    assign victim_dirty = victim ? dirty1 : dirty0;

endmodule

//--- cache_2ways/cache_2ways.sv
module cache_2ways (
    input logic         clk,
    input logic         rst,
    cache_port_if.array port
);

    cache_port_if way0_if ();
    cache_port_if way1_if ();

    logic hit0;
    logic hit1;
    logic victim;
    logic victim_q;
    logic victim_dirty;
    logic sel_way;
    logic state_way;
    logic touch;

    cache_oneline way0 (.clk(clk), .rst(rst), .port(way0_if));
    cache_oneline way1 (.clk(clk), .rst(rst), .port(way1_if));

    victim_select u_victim (
        .clk(clk), .rst(rst), .index(port.index),
        .valid0(way0_if.valid_out), .valid1(way1_if.valid_out),
        .dirty0(way0_if.dirty), .dirty1(way1_if.dirty),
        .touch(touch), .touch_way(sel_way),
        .victim(victim), .victim_dirty(victim_dirty)
    );

    // Hold victim through write-back and refill
    always_ff @(posedge clk) begin
        if (rst) begin
            victim_q <= 1'b0;
        end else if (port.enable && port.cmp) begin
            victim_q <= victim;
        end
    end

    ////////////////////
    // Request steering
    ////////////////////

    assign hit0 = way0_if.hit && way0_if.valid_out;
    assign hit1 = way1_if.hit && way1_if.valid_out;

    // Lookups reach both ways, line traffic only the victim
    assign way0_if.enable = port.enable && (port.cmp || !victim_q);
    assign way1_if.enable = port.enable && (port.cmp || victim_q);
    assign way0_if.write  = port.write && (port.cmp ? hit0 : !victim_q);
    assign way1_if.write  = port.write && (port.cmp ? hit1 : victim_q);

    // Shared request fields
    assign {way0_if.index, way0_if.word_sel, way0_if.cmp, way0_if.tag_in} =
        {port.index, port.word_sel, port.cmp, port.tag_in};
    assign {way1_if.index, way1_if.word_sel, way1_if.cmp, way1_if.tag_in} =
        {port.index, port.word_sel, port.cmp, port.tag_in};
    assign {way0_if.data_in, way0_if.valid_in, way0_if.byte_w_en} =
        {port.data_in, port.valid_in, port.byte_w_en};
    assign {way1_if.data_in, way1_if.valid_in, way1_if.byte_w_en} =
        {port.data_in, port.valid_in, port.byte_w_en};

    ////////////////////
    // Result muxing
    ////////////////////

    // Hitting way on lookup, latched victim otherwise
    assign sel_way   = port.cmp ? hit1 : victim_q;
    // Victim state, live during lookup so a miss can decide on write-back
    assign state_way = port.cmp ? victim : victim_q;

    assign port.hit       = hit0 || hit1;
    assign port.data_out  = sel_way ? way1_if.data_out : way0_if.data_out;
    assign port.tag_out   = sel_way ? way1_if.tag_out : way0_if.tag_out;
    assign port.valid_out = state_way ? way1_if.valid_out : way0_if.valid_out;
    assign port.dirty     = port.cmp ? victim_dirty
                                     : (victim_q ? way1_if.dirty : way0_if.dirty);

    // LRU update on lookup hit or on the word that completes a refill
    assign touch = port.enable &&
                   ((port.cmp && port.hit) || (!port.cmp && port.write && port.valid_in));

endmodule

//--- rtl/cache_ctrl.sv
module cache_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_req,
    input  logic                  cpu_we,
    input  cache_pkg::word_addr_t cpu_addr,
    input  cache_pkg::word_t      cpu_wdata,
    input  cache_pkg::byte_en_t   cpu_be,
    output logic                  cpu_ready,
    output logic                  cpu_done,
    output cache_pkg::word_t      cpu_rdata,
    output logic                  mem_rd,
    output logic                  mem_wr,
    output cache_pkg::word_addr_t mem_addr,
    output cache_pkg::word_t      mem_wdata,
    input  logic                  mem_ack,
    input  cache_pkg::word_t      mem_rdata,
    cache_port_if.ctrl            arr
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t state_next;
    // Word within the line being moved
    cache_pkg::offset_t     cnt;
    logic                   last_word;

    // Captured request
    logic                   req_we;
    cache_pkg::word_addr_t  req_addr;
    cache_pkg::word_t       req_wdata;
    cache_pkg::byte_en_t    req_be;
    cache_pkg::tag_t        req_tag;
    cache_pkg::index_t      req_index;
    cache_pkg::offset_t     req_offset;

    // Address fields, tag above index above offset
    assign req_offset = req_addr[cache_pkg::OFFSET_WIDTH-1:0];
    assign req_index  = req_addr[cache_pkg::OFFSET_WIDTH +: cache_pkg::INDEX_WIDTH];
    assign req_tag    = req_addr[cache_pkg::OFFSET_WIDTH + cache_pkg::INDEX_WIDTH +:
                                 cache_pkg::TAG_WIDTH];
    assign last_word  = (cnt == cache_pkg::offset_t'(cache_pkg::LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (state == cache_pkg::IDLE && cpu_req) begin
            req_we    <= cpu_we;
            req_addr  <= cpu_addr;
            req_wdata <= cpu_wdata;
            req_be    <= cpu_be;
        end
    end

    ////////////////////
    // State and counter
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::IDLE;
            cnt   <= '0;
        end else begin
            state <= state_next;
            // Wraps to zero after the last word of each burst
            if ((state == cache_pkg::WRITEBACK || state == cache_pkg::REFILL) && mem_ack) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::IDLE:      if (cpu_req) state_next = cache_pkg::LOOKUP;
            cache_pkg::LOOKUP: begin
                if (arr.hit) begin
                    state_next = cache_pkg::IDLE;
                end else if (arr.valid_out && arr.dirty) begin
                    state_next = cache_pkg::WRITEBACK;
                end else begin
                    state_next = cache_pkg::REFILL;
                end
            end
            cache_pkg::WRITEBACK: if (mem_ack && last_word) state_next = cache_pkg::REFILL;
            cache_pkg::REFILL:    if (mem_ack && last_word) state_next = cache_pkg::LOOKUP;
            default:              state_next = cache_pkg::IDLE;
        endcase
    end

    ////////////////////
    // Array requests
    ////////////////////

    always_comb begin
        arr.enable    = 1'b0;
        arr.index     = req_index;
        arr.word_sel  = req_offset;
        arr.cmp       = 1'b0;
        arr.write     = 1'b0;
        arr.tag_in    = req_tag;
        arr.data_in   = req_wdata;
        arr.valid_in  = 1'b0;
        arr.byte_w_en = req_be;
        case (state)
            cache_pkg::LOOKUP: begin
                // Store only lands if a way hits
                arr.enable = 1'b1;
                arr.cmp    = 1'b1;
                arr.write  = req_we;
            end
            cache_pkg::WRITEBACK: begin
                arr.enable   = 1'b1;
                arr.word_sel = cnt;
            end
            cache_pkg::REFILL: begin
                // One word per ack, line valid on the last one
                arr.enable   = 1'b1;
                arr.word_sel = cnt;
                arr.write    = mem_ack;
                arr.data_in  = mem_rdata;
                arr.valid_in = last_word;
            end
            default: ;
        endcase
    end

    ////////////////////
    // CPU and memory side
    ////////////////////

    assign cpu_ready = (state == cache_pkg::IDLE);
    assign cpu_done  = (state == cache_pkg::LOOKUP) && arr.hit;
    assign cpu_rdata = arr.data_out;

    assign mem_rd    = (state == cache_pkg::REFILL);
    assign mem_wr    = (state == cache_pkg::WRITEBACK);
    // Write-back goes to the victim's old tag
    assign mem_addr  = mem_wr ? {arr.tag_out, req_index, cnt} : {req_tag, req_index, cnt};
    assign mem_wdata = arr.data_out;

endmodule

//--- rtl/cache_top.sv
module cache_top (
    input  logic                  clk,
    input  logic                  rst,
    // CPU port
    input  logic                  cpu_req,
    input  logic                  cpu_we,
    input  cache_pkg::word_addr_t cpu_addr,
    input  cache_pkg::word_t      cpu_wdata,
    input  cache_pkg::byte_en_t   cpu_be,
    output logic                  cpu_ready,
    output logic                  cpu_done,
    output cache_pkg::word_t      cpu_rdata,
    // Memory port
    output logic                  mem_rd,
    output logic                  mem_wr,
    output cache_pkg::word_addr_t mem_addr,
    output cache_pkg::word_t      mem_wdata,
    input  logic                  mem_ack,
    input  cache_pkg::word_t      mem_rdata
);

    // Controller to array access port
    cache_port_if arr_if ();

    cache_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata), .cpu_be(cpu_be),
        .cpu_ready(cpu_ready), .cpu_done(cpu_done), .cpu_rdata(cpu_rdata),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .arr(arr_if)
    );

    cache_2ways u_array (
        .clk(clk),
        .rst(rst),
        .port(arr_if)
    );

endmodule

//--- testbench/cache_tb.sv
module cache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 200;

    // Table row with its expected load data filled in when applied
    typedef struct {
        string                 name;
        bit                    is_store;
        cache_pkg::word_addr_t addr;
        cache_pkg::word_t      data;
        cache_pkg::byte_en_t   be;
        cache_pkg::word_t      exp;
        bit                    exp_hit;
        int                    exp_wb;
        cache_pkg::word_addr_t wb_base;
    } test_t;

    logic                  clk;
    logic                  rst;
    logic                  cpu_req;
    logic                  cpu_we;
    cache_pkg::word_addr_t cpu_addr;
    cache_pkg::word_t      cpu_wdata;
    cache_pkg::byte_en_t   cpu_be;
    logic                  cpu_ready;
    logic                  cpu_done;
    cache_pkg::word_t      cpu_rdata;
    logic                  mem_rd;
    logic                  mem_wr;
    cache_pkg::word_addr_t mem_addr;
    cache_pkg::word_t      mem_wdata;
    logic                  mem_ack;
    cache_pkg::word_t      mem_rdata;

    // Backing memory and the expected image
    cache_pkg::word_t      mem_image [cache_pkg::word_addr_t];
    cache_pkg::word_t      ref_image [cache_pkg::word_addr_t];
    // Write-backs seen during the current test
    cache_pkg::word_addr_t wb_addr_log [$];
    cache_pkg::word_t      wb_data_log [$];
    int unsigned           lcg_state = 20205;
    test_t                 tests [$];
    int                    checks;
    int                    errors;
    bit                    timed_out;

    cache_top u_cache_top (
        .clk(clk), .rst(rst),
        .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata), .cpu_be(cpu_be),
        .cpu_ready(cpu_ready), .cpu_done(cpu_done), .cpu_rdata(cpu_rdata),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // Unwritten memory content
    function automatic cache_pkg::word_t fill_pattern(cache_pkg::word_addr_t addr);
        return {2'b00, addr} ^ 32'hA5A5A5A5;
    endfunction

    function automatic cache_pkg::word_t ref_read(cache_pkg::word_addr_t addr);
        return ref_image.exists(addr) ? ref_image[addr] : fill_pattern(addr);
    endfunction

    // Byte-lane merge of a CPU store
    function automatic void ref_store(cache_pkg::word_addr_t addr, cache_pkg::word_t data,
                                      cache_pkg::byte_en_t be);
        cache_pkg::word_t word;
        word = ref_read(addr);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) word[8*b +: 8] = data[8*b +: 8];
        end
        ref_image[addr] = word;
    endfunction

    function automatic void add_test(string name, bit is_store, cache_pkg::word_addr_t addr,
                                     cache_pkg::word_t data, cache_pkg::byte_en_t be,
                                     bit exp_hit, int exp_wb, cache_pkg::word_addr_t wb_base);
        test_t t;
        t.name     = name;
        t.is_store = is_store;
        t.addr     = addr;
        t.data     = data;
        t.be       = be;
        t.exp      = '0;
        t.exp_hit  = exp_hit;
        t.exp_wb   = exp_wb;
        t.wb_base  = wb_base;
        tests.push_back(t);
    endfunction

    task automatic check_word(string what, cache_pkg::word_t got, cache_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(string what, cache_pkg::word_addr_t got,
                              cache_pkg::word_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expect_true(bit cond, string text);
        checks++;
        if (!cond) begin
            errors++;
            $display("error at %0d ns: %s", $time, text);
        end
    endtask

    ////////////////////
    // Memory model
    ////////////////////

    initial begin
        int unsigned gap;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && (mem_rd || mem_wr)) begin
                // Ack 1 to 4 cycles after the request is seen
                gap = lcg_next() % 4;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                if (mem_wr) begin
                    mem_image[mem_addr] = mem_wdata;
                    wb_addr_log.push_back(mem_addr);
                    wb_data_log.push_back(mem_wdata);
                end else begin
                    mem_rdata = mem_image.exists(mem_addr) ? mem_image[mem_addr]
                                                           : fill_pattern(mem_addr);
                end
                mem_ack = 1'b1;
                @(posedge clk);
                #1;
                mem_ack = 1'b0;
            end
        end
    end

    ////////////////////
    // CPU side
    ////////////////////

    task automatic wait_ready(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < TIMEOUT_CYCLES; n++) begin
            @(posedge clk);
            #1;
            if (cpu_ready) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    // Entered 1 ns after an edge and left 1 ns after the next one
    task automatic issue_request(test_t t);
        cpu_req   = 1'b1;
        cpu_we    = t.is_store;
        cpu_addr  = t.addr;
        cpu_wdata = t.data;
        cpu_be    = t.be;
        @(posedge clk);
        #1;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
    endtask

    // Cycles counted at falling edges from the request edge
    task automatic wait_done(output int cycles, output bit saw_rd, output bit saw_ready,
                             output cache_pkg::word_t rdata, output bit ok);
        cycles    = 0;
        saw_rd    = 1'b0;
        saw_ready = 1'b0;
        rdata     = '0;
        ok        = 1'b0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (mem_rd) saw_rd = 1'b1;
            if (cpu_ready) saw_ready = 1'b1;
            if (cpu_done) begin
                rdata = cpu_rdata;
                ok    = 1'b1;
                break;
            end
        end
    endtask

    ////////////////////
    // Stimulus and report
    ////////////////////

    initial begin
        int                    cycles;
        bit                    saw_rd;
        bit                    saw_ready;
        bit                    ok;
        int                    errs_before;
        cache_pkg::word_t      rdata;
        cache_pkg::word_addr_t wb_exp_addr;
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_be    = '0;
        checks    = 0;
        errors    = 0;
        timed_out = 1'b0;

        // Set 5 holds tags 1, 2 and 3 in turn and set 9 takes a store miss
        add_test("load miss A",        0, 30'h22A, 32'h0,        4'b0000, 0, 0, 30'h0);
        add_test("store hit A",        1, 30'h22A, 32'h11223344, 4'b0101, 1, 0, 30'h0);
        add_test("store hit A+5",      1, 30'h22D, 32'hCAFEF00D, 4'b1111, 1, 0, 30'h0);
        add_test("load merged A",      0, 30'h22A, 32'h0,        4'b0000, 1, 0, 30'h0);
        add_test("load miss B",        0, 30'h42B, 32'h0,        4'b0000, 0, 0, 30'h0);
        add_test("reload A",           0, 30'h22A, 32'h0,        4'b0000, 1, 0, 30'h0);
        add_test("reload B",           0, 30'h42B, 32'h0,        4'b0000, 1, 0, 30'h0);
        add_test("load C evicts A",    0, 30'h629, 32'h0,        4'b0000, 0, 8, 30'h228);
        add_test("load written A+5",   0, 30'h22D, 32'h0,        4'b0000, 0, 0, 30'h0);
        add_test("load written A",     0, 30'h22A, 32'h0,        4'b0000, 1, 0, 30'h0);
        add_test("store miss D",       1, 30'hE4C, 32'hDEADBEEF, 4'b1000, 0, 0, 30'h0);
        add_test("load D",             0, 30'hE4C, 32'h0,        4'b0000, 1, 0, 30'h0);

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle outputs right out of reset
        expect_true(cpu_ready, "cache not ready after reset");
        expect_true(!cpu_done && !mem_rd && !mem_wr, "cache busy after reset");

        for (int i = 0; i < tests.size(); i++) begin
            errs_before = errors;
            wb_addr_log.delete();
            wb_data_log.delete();
            wait_ready(ok);
            if (!ok) begin
                $display("timeout: cache not ready for test %0d", i);
                timed_out = 1'b1;
                break;
            end
            tests[i].exp = ref_read(tests[i].addr);
            issue_request(tests[i]);
            wait_done(cycles, saw_rd, saw_ready, rdata, ok);
            if (!ok) begin
                $display("timeout: no cpu_done within %0d cycles on test %0d",
                         TIMEOUT_CYCLES, i);
                timed_out = 1'b1;
                break;
            end
            if (!tests[i].is_store) check_word("load data", rdata, tests[i].exp);
            expect_true(!saw_ready, "cache ready while a request was in progress");
            if (tests[i].exp_hit) begin
                expect_true(cycles == 1, "hit did not finish one cycle after its request");
                expect_true(!saw_rd, "hit read from memory");
            end else begin
                expect_true(saw_rd, "miss did not refill from memory");
            end
            expect_true(wb_addr_log.size() == tests[i].exp_wb, "wrong number of write-backs");
            // Evicted line goes out in offset order and matches the image
            for (int j = 0; j < wb_addr_log.size() && j < tests[i].exp_wb; j++) begin
                wb_exp_addr = tests[i].wb_base + cache_pkg::word_addr_t'(j);
                check_addr("write-back address", wb_addr_log[j], wb_exp_addr);
                check_word("write-back data", wb_data_log[j], ref_read(wb_exp_addr));
            end
            if (tests[i].is_store) ref_store(tests[i].addr, tests[i].data, tests[i].be);
            $display("test %0d %s: %s (%0d cycles)", i, tests[i].name,
                     (errors == errs_before) ? "ok" : "failed", cycles);
        end

        $display("%0d tests, %0d checks, %0d errors", tests.size(), checks, errors);
        if (timed_out || errors != 0) begin
            $display("STATUS: FAIL");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

//--- build.f
common/cache_pkg.sv
common/cache_port_if.sv
cache_2ways/cache_oneline.sv
cache_2ways/victim_select.sv
cache_2ways/cache_2ways.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
testbench/cache_tb.sv

//--- Bender.yml
package:
  name: cache_2ways

sources:
  - common/cache_pkg.sv
  - common/cache_port_if.sv
  - cache_2ways/cache_oneline.sv
  - cache_2ways/victim_select.sv
  - cache_2ways/cache_2ways.sv
  - rtl/cache_ctrl.sv
  - rtl/cache_top.sv
  - target: simulation
    files:
      - testbench/cache_tb.sv
